// ==== dv/tcu_core_tb.sv ====
// ------------------------------
// TCU core testbench
// Replays the golden requests in
// isolated, back-to-back and
// randomly stalled phases and
// checks every result tile
// ------------------------------

`timescale 1ns/100ps

module tcu_core_tb;

    localparam int NUM_RECS    = 11;
    localparam int REC_WORDS   = 20;
    // Records 0..3 go one at a time, 4..7 back to back, the rest under stalls
    localparam int ISO_LAST    = 3;
    localparam int B2B_LAST    = 7;
    localparam int RSP_LATENCY = 4;
    // Two golden lines per record, three cycles each plus reset and drain
    localparam int GOLDEN_LINES   = NUM_RECS * 2;
    localparam int TIMEOUT_CYCLES = GOLDEN_LINES * 3 + 20;

    logic              clk = 1'b0;
    logic              reset;
    logic              in_valid;
    logic              in_ready;
    tcu_pkg::tcu_req_t in_req;
    logic              out_valid;
    logic              out_ready;
    tcu_pkg::tcu_rsp_t out_rsp;

    logic [31:0]       golden [NUM_RECS*REC_WORDS];
    int                accept_edge [NUM_RECS];
    int                cycle = 0;
    int                rsp_count = 0;
    int                err_data = 0;
    int                err_timing = 0;
    int                err_proto = 0;
    logic              stall_phase = 1'b0;
    logic [15:0]       lfsr = 16'd49969;
    logic              held = 1'b0;
    tcu_pkg::tcu_rsp_t held_rsp;

    tcu_core_top tcu_core_top_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rsp   (out_rsp)
    );

    always #20 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic tcu_pkg::tcu_req_t build_req(input int idx);
        tcu_pkg::tcu_req_t req;
        int                base;
        base = idx * REC_WORDS;
        req.header.tag = golden[base][7:0];
        req.header.wid = golden[base+1][3:0];
        req.step_m     = golden[base+2][0];
        req.step_n     = golden[base+3][0];
        // Word q carries elements 4q..4q+3, lowest byte first
        for (int q = 0; q < 4; q++) begin
            for (int b = 0; b < 4; b++) begin
                req.a_reg[4*q+b] = golden[base+4+q][8*b +: 8];
                req.b_reg[4*q+b] = golden[base+8+q][8*b +: 8];
            end
            req.c_reg[q] = golden[base+12+q];
        end
        return req;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            err_data++;
        end
    endtask

    task automatic check_response(input int idx);
        int base;
        base = idx * REC_WORDS;
        check_value($sformatf("rec%0d tag", idx), golden[base][7:0], out_rsp.header.tag);
        check_value($sformatf("rec%0d wid", idx), golden[base+1][3:0], out_rsp.header.wid);
        for (int t = 0; t < 4; t++) begin
            check_value($sformatf("rec%0d d_tile[%0d]", idx, t), golden[base+16+t],
                        out_rsp.d_tile[t]);
        end
        // Fixed latency holds only while out_ready stays high
        if (idx <= B2B_LAST) begin
            assert (cycle + 1 - accept_edge[idx] == RSP_LATENCY) else begin
                $display("ERR rec%0d latency expected %0d actual %0d", idx, RSP_LATENCY,
                         cycle + 1 - accept_edge[idx]);
                err_timing++;
            end
        end
    endtask

    task automatic send_records(input int first, input int last, input bit isolated);
        int idx;
        idx = first;
        while (idx <= last) begin
            @(posedge clk);
            in_valid <= 1'b1;
            in_req   <= build_req(idx);
            @(negedge clk);
            while (!in_ready) begin
                @(negedge clk);
            end
            accept_edge[idx] = cycle + 1;
            // Back-to-back records are taken on consecutive edges
            if (!isolated && idx > first && idx <= B2B_LAST) begin
                assert (accept_edge[idx] == accept_edge[idx-1] + 1) else begin
                    $display("ERR rec%0d accept edge expected %0d actual %0d", idx,
                             accept_edge[idx-1] + 1, accept_edge[idx]);
                    err_timing++;
                end
            end
            if (isolated) begin
                @(posedge clk);
                in_valid <= 1'b0;
                wait (rsp_count > idx);
            end
            idx++;
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    always @(posedge clk) begin : ready_gen
        logic [15:0] next;
        next = lfsr_step(lfsr);
        if (stall_phase) begin
            lfsr      <= next;
            out_ready <= next[0];
        end else begin
            out_ready <= 1'b1;
        end
    end

    // Outputs are sampled half a cycle away from the driving edge
    always @(negedge clk) begin : monitor
        if (!reset && held) begin
            assert (out_valid && out_rsp == held_rsp) else begin
                $display("Response changed or vanished while the output was stalled");
                err_proto++;
            end
        end
        held     = !reset && out_valid && !out_ready;
        held_rsp = out_rsp;
        if (held) begin
            assert (!in_ready) else begin
                $display("in_ready was high while the output was stalled");
                err_proto++;
            end
        end
        if (!reset && out_valid && out_ready) begin
            assert (rsp_count < NUM_RECS) else begin
                $display("A response arrived after the last golden record");
                err_proto++;
            end
            if (rsp_count < NUM_RECS) begin
                check_response(rsp_count);
            end
            rsp_count++;
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin : main
        in_valid  = 1'b0;
        in_req    = '0;
        out_ready = 1'b1;
        reset     = 1'b1;
        $readmemh("dv/tcu_golden.dat", golden);
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!out_valid && in_ready) else begin
            $display("Handshake outputs wrong right after reset");
            err_proto++;
        end
        send_records(0, ISO_LAST, 1'b1);
        send_records(ISO_LAST + 1, B2B_LAST, 1'b0);
        wait (rsp_count > B2B_LAST);
        @(negedge clk);
        stall_phase = 1'b1;
        send_records(B2B_LAST + 1, NUM_RECS - 1, 1'b0);
        wait (rsp_count == NUM_RECS);
        @(negedge clk);
        stall_phase = 1'b0;
        repeat (3) @(negedge clk);
        assert (!out_valid && in_ready) else begin
            $display("Pipeline did not return to idle after the last response");
            err_proto++;
        end
        $display("Errors: data %0d, timing %0d, protocol %0d", err_data, err_timing, err_proto);
        if (err_data + err_timing + err_proto == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== dv/tcu_golden.dat ====
// tag wid step_m step_n a_reg[4 words] b_reg[4 words], then c_reg[4] d_tile[4] on the next line
// word n of a_reg or b_reg holds elements 4n..4n+3, element 4n in the low byte
10 1 0 0 04030201 08070605 09090909 09090909 01010101 00ff0001 07070707 07070707
00000000 00000000 00000000 00000000 0000000a fffffffe 0000001a fffffffe
11 2 0 1 0300ff02 000105fc 0b0b0b0b 0b0b0b0b 03030303 03030303 04030201 0202ffff
00000064 ffffff9c 00000000 00000007 00000070 ffffffa1 00000009 00000008
12 3 1 0 01010101 01010101 281e140a d8e2ecf6 ff01ff01 02020202 05050505 05050505
00001000 00000000 ffffffff 00000000 00000fec 000000c8 00000013 ffffff38
13 4 1 1 02020202 02020202 80808080 7f7f7f7f 03030303 03030303 80808080 7f7f7f7f
00000000 00000000 00000000 00000000 00010000 ffff0200 ffff0200 0000fc04
20 5 0 0 00000001 ff000000 04040404 04040404 01010101 02000003 06060606 06060606
7fffffff 7ffffffe 00000005 80000000 80000000 80000001 00000004 7ffffffe
21 6 1 1 7f7f7f7f 7f7f7f7f 04030201 fcfdfeff 7f7f7f7f 7f7f7f7f 01020304 0a000000
00000001 00000002 00000003 00000004 00000015 0000002a ffffffef ffffffdc
22 7 1 0 10101010 10101010 00000000 64646464 9c9c9c9c 04030201 20202020 20202020
deadbeef 00000000 00000000 fffffc18 deadbeef 00000000 ffff63c0 00000000
23 8 0 1 ffffffff 00020002 30303030 30303030 40404040 40404040 08070605 01f901f9
00000000 00000010 00000000 80000000 ffffffe6 0000001c 00000018 7fffffe4
30 9 0 0 0001807f 03030303 50505050 50505050 00007f7f 00008080 60606060 60606060
00000000 00000000 00000000 00000000 ffffff81 00000080 000002fa fffffd00
31 a 1 0 11111111 11111111 01010101 0100ff00 06070809 fefefefe 22222222 22222222
00000100 ffffff00 12345678 00000000 0000011e fffffef8 12345676 00000000
32 b 0 1 05050505 02fd04fb 33333333 33333333 44444444 44444444 00000001 ffffffff
fffffffb 00000015 00000000 7fffffff 00000000 00000001 fffffffb 80000001

// ==== logic/tcu_core_top.sv ====
// ------------------------------
// TCU core top level
// Computes D = A*B + C on a 2x2
// tile with operand, dot-unit
// and result stages
// ------------------------------

`timescale 1ns/100ps

module tcu_core_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    output logic                in_ready,
    input  tcu_pkg::tcu_req_t   in_req,
    output logic                out_valid,
    input  logic                out_ready,
    output tcu_pkg::tcu_rsp_t   out_rsp
);

    logic enable;

    tcu_pkg::elem_t [tcu_pkg::TC_M-1:0][tcu_pkg::TC_K-1:0] a_rows;
    tcu_pkg::elem_t [tcu_pkg::TC_N-1:0][tcu_pkg::TC_K-1:0] b_cols;
    tcu_pkg::acc_t  [tcu_pkg::TC_M*tcu_pkg::TC_N-1:0]      c_vals;
    tcu_pkg::acc_t  [tcu_pkg::TC_M*tcu_pkg::TC_N-1:0]      d_vals;

    tcu_operand_select tcu_operand_select_i (
        .clk    (clk),
        .in_req (in_req),
        .enable (enable),
        .a_rows (a_rows),
        .b_cols (b_cols),
        .c_vals (c_vals)
    );

    // One dot unit per tile element
    for (genvar i = 0; i < tcu_pkg::TC_M; i++) begin : g_row
        for (genvar j = 0; j < tcu_pkg::TC_N; j++) begin : g_col
            tcu_dot_unit tcu_dot_unit_i (
                .clk    (clk),
                .reset  (reset),
                .enable (enable),
                .a_row  (a_rows[i]),
                .b_col  (b_cols[j]),
                .c_val  (c_vals[i * tcu_pkg::TC_N + j]),
                .d_val  (d_vals[i * tcu_pkg::TC_N + j])
            );
        end
    end

    tcu_result_collect tcu_result_collect_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_header (in_req.header),
        .d_vals    (d_vals),
        .enable    (enable),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rsp   (out_rsp)
    );

endmodule

// ==== logic/tcu_dot_unit.sv ====
// ------------------------------
// TCU dot-product unit
// Three-stage signed K-way dot
// product plus accumulator,
// wrapping at 32 bits
// ------------------------------

`timescale 1ns/100ps

module tcu_dot_unit (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  enable,
    input  tcu_pkg::elem_t [tcu_pkg::TC_K-1:0]    a_row,
    input  tcu_pkg::elem_t [tcu_pkg::TC_K-1:0]    b_col,
    input  tcu_pkg::acc_t                         c_val,
    output tcu_pkg::acc_t                         d_val
);

    // Stage 1, full-precision products
    logic signed [15:0] prod [tcu_pkg::TC_K];
    tcu_pkg::acc_t      c_s1;

    // Stage 2, one extra bit for the pair add
    logic signed [16:0] pair_sum [tcu_pkg::TC_K/2];
    tcu_pkg::acc_t      c_s2;

    always_ff @(posedge clk) begin
        if (reset) begin
            prod <= '{default: '0};
            c_s1 <= '0;
        end else if (enable) begin
            for (int k = 0; k < tcu_pkg::TC_K; k++) begin
                prod[k] <= $signed(a_row[k]) * $signed(b_col[k]);
            end
            c_s1 <= c_val;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pair_sum <= '{default: '0};
            c_s2     <= '0;
        end else if (enable) begin
            for (int p = 0; p < tcu_pkg::TC_K / 2; p++) begin
                pair_sum[p] <= 17'(prod[2*p]) + 17'(prod[2*p+1]);
            end
            c_s2 <= c_s1;
        end
    end

    // Stage 3, sign-extend partials and wrap on overflow
    always_ff @(posedge clk) begin
        if (reset) begin
            d_val <= '0;
        end else if (enable) begin
            d_val <= tcu_pkg::acc_t'(pair_sum[0])
                   + tcu_pkg::acc_t'(pair_sum[1])
                   + c_s2;
        end
    end

endmodule

// ==== logic/tcu_operand_select.sv ====
// ------------------------------
// TCU operand stage
// Selects the A and B sub-blocks,
// gathers rows, columns and the
// accumulators, and registers
// them under the stall enable
// ------------------------------

`timescale 1ns/100ps

module tcu_operand_select (
    input  logic                                               clk,
    input  tcu_pkg::tcu_req_t                                  in_req,
    input  logic                                               enable,
    output tcu_pkg::elem_t [tcu_pkg::TC_M-1:0][tcu_pkg::TC_K-1:0] a_rows,
    output tcu_pkg::elem_t [tcu_pkg::TC_N-1:0][tcu_pkg::TC_K-1:0] b_cols,
    output tcu_pkg::acc_t  [tcu_pkg::TC_M*tcu_pkg::TC_N-1:0]      c_vals
);

    // Base element of each selected sub-block
    int unsigned a_off;
    int unsigned b_off;

    tcu_pkg::elem_t [tcu_pkg::TC_M-1:0][tcu_pkg::TC_K-1:0] a_sel;
    tcu_pkg::elem_t [tcu_pkg::TC_N-1:0][tcu_pkg::TC_K-1:0] b_sel;
    tcu_pkg::acc_t  [tcu_pkg::TC_M*tcu_pkg::TC_N-1:0]      c_sel;

    always_comb begin
        a_off = int'(in_req.step_m) * tcu_pkg::BLOCK_ELEMS;
        b_off = int'(in_req.step_n) * tcu_pkg::BLOCK_ELEMS;
    end

    // Row i of A and column j of B, K elements each
    always_comb begin
        for (int i = 0; i < tcu_pkg::TC_M; i++) begin
            for (int k = 0; k < tcu_pkg::TC_K; k++) begin
                a_sel[i][k] = in_req.a_reg[a_off + i * tcu_pkg::TC_K + k];
            end
        end
        for (int j = 0; j < tcu_pkg::TC_N; j++) begin
            for (int k = 0; k < tcu_pkg::TC_K; k++) begin
                b_sel[j][k] = in_req.b_reg[b_off + j * tcu_pkg::TC_K + k];
            end
        end
    end

    // Accumulators follow the row-major tile order
    always_comb begin
        for (int i = 0; i < tcu_pkg::TC_M; i++) begin
            for (int j = 0; j < tcu_pkg::TC_N; j++) begin
                c_sel[i * tcu_pkg::TC_N + j] = in_req.c_reg[i * tcu_pkg::TC_N + j];
            end
        end
    end

    // Pure payload, frozen while the output is stalled
    always_ff @(posedge clk) begin
        if (enable) begin
            a_rows <= a_sel;
            b_cols <= b_sel;
            c_vals <= c_sel;
        end
    end

    // An unknown step would scatter X into every dot unit
    a_step_known: assert property (
        @(posedge clk) enable |-> !$isunknown({in_req.step_m, in_req.step_n})
    );

endmodule

// ==== logic/tcu_pkg.sv ====
// ------------------------------
// TCU shared definitions
// Tile shape, pipeline depths,
// element types and the request
// and response structs of the
// matrix multiply core
// ------------------------------

package tcu_pkg;

    // Result tile is TC_M x TC_N, reduction depth TC_K
    localparam int TC_M = 2;
    localparam int TC_N = 2;
    localparam int TC_K = 4;

    // Operand register layout
    localparam int SUB_BLOCKS  = 2;
    localparam int BLOCK_ELEMS = TC_M * TC_K;
    localparam int REG_ELEMS   = SUB_BLOCKS * BLOCK_ELEMS;

    // Multiply, pair add, final add
    localparam int DOT_LATENCY  = 3;
    // Operand register in front of the dot units
    localparam int PIPE_LATENCY = DOT_LATENCY + 1;
    localparam int META_DEPTH   = 1 << $clog2(PIPE_LATENCY);

    typedef logic signed [7:0]  elem_t;
    typedef logic signed [31:0] acc_t;
    typedef logic [3:0]         wid_t;
    typedef logic [7:0]         tag_t;
    // Sub-block selector
    typedef logic [0:0]         step_t;

    // Travels alongside the data, 12 bits
    typedef struct packed {
        wid_t wid;
        tag_t tag;
    } tcu_header_t;

    typedef struct packed {
        tcu_header_t                  header;
        step_t                        step_m;
        step_t                        step_n;
        elem_t [REG_ELEMS-1:0]        a_reg;
        // Columns stored contiguously
        elem_t [REG_ELEMS-1:0]        b_reg;
        acc_t  [TC_M*TC_N-1:0]        c_reg;
    } tcu_req_t;

    // Tile is row-major, index i * TC_N + j
    typedef struct packed {
        tcu_header_t                  header;
        acc_t  [TC_M*TC_N-1:0]        d_tile;
    } tcu_rsp_t;

endpackage

// ==== logic/tcu_result_collect.sv ====
// ------------------------------
// TCU result stage
// Tracks requests in flight,
// queues their headers, drives
// both handshakes and the stall
// enable, and packs the result
// ------------------------------

`timescale 1ns/100ps

module tcu_result_collect (
    input  logic                                             clk,
    input  logic                                             reset,
    input  logic                                             in_valid,
    output logic                                             in_ready,
    input  tcu_pkg::tcu_header_t                             in_header,
    input  tcu_pkg::acc_t [tcu_pkg::TC_M*tcu_pkg::TC_N-1:0]  d_vals,
    output logic                                             enable,
    output logic                                             out_valid,
    input  logic                                             out_ready,
    output tcu_pkg::tcu_rsp_t                                out_rsp
);

    logic in_fire;
    logic out_fire;

    // One bit per pipeline slot, bit 0 is the output slot
    logic [tcu_pkg::PIPE_LATENCY-1:0] delay_line;

    tcu_pkg::tcu_header_t                  meta_mem [tcu_pkg::META_DEPTH];
    logic [$clog2(tcu_pkg::META_DEPTH)-1:0] wr_ptr;
    logic [$clog2(tcu_pkg::META_DEPTH)-1:0] rd_ptr;
    logic [$clog2(tcu_pkg::META_DEPTH):0]   meta_count;
    logic                                  meta_full;
    logic                                  meta_empty;

    assign in_fire  = in_valid && in_ready;
    assign out_fire = out_valid && out_ready;

    // Whole pipeline freezes while a result waits
    assign enable    = !out_valid || out_ready;
    assign in_ready  = enable && !meta_full;
    assign out_valid = delay_line[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            delay_line <= '0;
        end else begin
            if (enable) begin
                delay_line <= delay_line >> 1;
            end
            if (in_fire) begin
                delay_line[tcu_pkg::PIPE_LATENCY-1] <= 1'b1;
            end
        end
    end

    // Header queue
    assign meta_full  = (meta_count == tcu_pkg::META_DEPTH);
    assign meta_empty = (meta_count == '0);

    always_ff @(posedge clk) begin
        if (in_fire) begin
            meta_mem[wr_ptr] <= in_header;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            meta_count <= '0;
        end else begin
            if (in_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (out_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({in_fire, out_fire})
                2'b10:   meta_count <= meta_count + 1'b1;
                2'b01:   meta_count <= meta_count - 1'b1;
                default: meta_count <= meta_count;
            endcase
        end
    end

    // Head entry lines up with the dot-unit outputs
    assign out_rsp.header = meta_mem[rd_ptr];
    assign out_rsp.d_tile = d_vals;

    // Queue occupancy always equals the requests in flight
    a_meta_tracks_delay: assert property (
        @(posedge clk) disable iff (reset) meta_count == $countones(delay_line)
    );
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (reset) out_fire |-> !meta_empty
    );
    a_out_stable: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_rsp)
    );
    a_valid_has_meta: assert property (
        @(posedge clk) disable iff (reset) out_valid |-> !meta_empty
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the TCU core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f sources.f --top-module tcu_core_tb -o tcu_core_sim
output="$(./obj_dir/tcu_core_sim)"
echo "$output"

if grep -q "All tests passed" <<< "$output"; then
    exit 0
fi
exit 1

// ==== sources.f ====
logic/tcu_pkg.sv
logic/tcu_operand_select.sv
logic/tcu_dot_unit.sv
logic/tcu_result_collect.sv
logic/tcu_core_top.sv
dv/tcu_core_tb.sv
